// ==== files.f ====
hw/segre_pkg.sv
hw/segre_tl_stage.sv
hw/segre_store_buffer.sv
hw/segre_mmu.sv
hw/segre_mem_stage.sv
hw/segre_mem_subsys.sv
tests/segre_main_memory_model.sv
tests/tb_segre_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: segre_mem_subsys

sources:
  - hw/segre_pkg.sv
  - hw/segre_tl_stage.sv
  - hw/segre_store_buffer.sv
  - hw/segre_mmu.sv
  - hw/segre_mem_stage.sv
  - hw/segre_mem_subsys.sv
  - target: test
    files:
      - tests/segre_main_memory_model.sv
      - tests/tb_segre_mem_subsys.sv

// ==== tests/segre_mem_tests.txt ====
# op type sign addr data rd expected; op is L load, S store, G group name
# type is B, H or W; addr, data and expected in hex; sign and rd in decimal
G initial_loads
L W 0 00000100 00000000 1 a5a5a4a5
L H 1 00000106 00000000 2 ffffa5a5
L H 0 00000104 00000000 3 0000a4a1
L B 0 00000109 00000000 4 000000a4
L B 1 00000080 00000000 5 00000025
G cache_hits
L W 0 00000200 00000000 6 a5a5a7a5
L W 0 00000204 00000000 7 a5a5a7a1
L W 0 00000208 00000000 8 a5a5a7ad
L W 0 00000200 00000000 9 a5a5a7a5
G store_then_load
S W 0 00000300 deadbeef 0 00000000
L W 0 00000300 00000000 10 deadbeef
S B 0 00000301 00000042 0 00000000
L B 1 00000301 00000000 11 00000042
S H 0 00000302 00008001 0 00000000
L W 0 00000300 00000000 12 800142ef
G merge_after_eviction
S B 0 00000412 0000005a 0 00000000
S H 0 00000416 00001234 0 00000000
S W 0 00000418 cafef00d 0 00000000
L W 0 00000450 00000000 13 a5a5a1f5
L W 0 00000410 00000000 14 a55aa1b5
L W 0 00000414 00000000 15 1234a1b1
L W 0 00000418 00000000 16 cafef00d
G store_burst
S W 0 00000520 11111111 0 00000000
S W 0 00000530 22222222 0 00000000
S W 0 00000524 33333333 0 00000000
S H 0 00000534 00004444 0 00000000
S B 0 0000052b 00000077 0 00000000
L W 0 00000520 00000000 17 11111111
L W 0 00000524 00000000 18 33333333
L W 0 00000528 00000000 19 77a5a08d
L W 0 00000530 00000000 20 22222222
L W 0 00000534 00000000 21 a5a54444

// ==== tests/tb_segre_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_segre_mem_subsys;

    localparam int CLK_PERIOD   = 4;
    localparam int SB_DEPTH     = 4;
    localparam int DCACHE_LINES = 4;

    // One record of the test file
    typedef struct packed {
        logic [7:0]                  kind;
        segre_pkg::memop_data_type_e mtype;
        logic                        sign;
        logic [31:0]                 addr;
        logic [31:0]                 data;
        logic [4:0]                  rd;
        logic [31:0]                 expected;
    } test_rec_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
    } load_exp_t;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   op_valid;
    segre_pkg::core_tl_t                    op;
    logic                                   hazard;
    logic [segre_pkg::WORD_SIZE-1:0]        op_res;
    logic                                   rf_we;
    logic [segre_pkg::REG_ADDR_SIZE-1:0]    rf_waddr;
    logic                                   mm_data_rdy;
    logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_rd_data;
    logic [segre_pkg::WORD_SIZE-1:0]        mm_wr_data;
    logic [segre_pkg::ADDR_SIZE-1:0]        mm_addr;
    logic [segre_pkg::ADDR_SIZE-1:0]        mm_wr_addr;
    logic                                   mm_rd;
    logic                                   mm_wr;
    segre_pkg::memop_data_type_e            mm_wr_data_type;

    test_rec_t            tests[$];
    logic [8*24-1:0]      group_names[$];
    load_exp_t            load_q[$];
    segre_pkg::sb_entry_t store_q[$];
    logic [31:0]          last_load_addr;
    int                   errors;
    int                   checks;
    int                   num_lines;

    segre_mem_subsys #(
        .SB_DEPTH     (SB_DEPTH),
        .DCACHE_LINES (DCACHE_LINES)
    ) UUT (
        .clk_i             (clk),
        .rst_n_i           (rst_n),
        .op_valid_i        (op_valid),
        .op_i              (op),
        .hazard_o          (hazard),
        .op_res_o          (op_res),
        .rf_we_o           (rf_we),
        .rf_waddr_o        (rf_waddr),
        .mm_data_rdy_i     (mm_data_rdy),
        .mm_rd_data_i      (mm_rd_data),
        .mm_wr_data_o      (mm_wr_data),
        .mm_addr_o         (mm_addr),
        .mm_wr_addr_o      (mm_wr_addr),
        .mm_rd_o           (mm_rd),
        .mm_wr_o           (mm_wr),
        .mm_wr_data_type_o (mm_wr_data_type)
    );

    segre_main_memory_model #(
        .MEM_WORDS (1024),
        .SEED      (32'd33)
    ) mem_model (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .mm_rd_i       (mm_rd),
        .mm_wr_i       (mm_wr),
        .mm_addr_i     (mm_addr),
        .mm_wr_addr_i  (mm_wr_addr),
        .mm_wr_data_i  (mm_wr_data),
        .mm_wr_type_i  (mm_wr_data_type),
        .mm_data_rdy_o (mm_data_rdy),
        .mm_rd_data_o  (mm_rd_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic read_tests();
        int              fd;
        int              code;
        int              sgn;
        int              rd;
        logic [7:0]      kind;
        logic [7:0]      tchar;
        logic [31:0]     addr;
        logic [31:0]     data;
        logic [31:0]     expv;
        logic [8*24-1:0] name;
        logic [8*96-1:0] line;
        test_rec_t       rec;
        fd = $fopen("tests/segre_mem_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open tests/segre_mem_tests.txt");
            return;
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            num_lines++;
            rec      = '0;
            rec.kind = kind;
            if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "G") begin
                code     = $fscanf(fd, " %s", name);
                rec.data = group_names.size();
                group_names.push_back(name);
                tests.push_back(rec);
            end else begin
                code = $fscanf(fd, " %c %d %h %h %d %h", tchar, sgn, addr, data, rd, expv);
                rec.mtype = (tchar == "B") ? segre_pkg::BYTE :
                            (tchar == "H") ? segre_pkg::HALF : segre_pkg::WORD;
                rec.sign     = sgn[0];
                rec.addr     = addr;
                rec.data     = data;
                rec.rd       = rd[4:0];
                rec.expected = expv;
                tests.push_back(rec);
            end
        end
        $fclose(fd);
    endtask

    // Called right after a rising edge
    task automatic issue_op(input test_rec_t rec);
        segre_pkg::core_tl_t  next_op;
        load_exp_t            ld;
        segre_pkg::sb_entry_t st;
        next_op                = '0;
        next_op.alu_res        = rec.addr;
        next_op.rf_st_data     = rec.data;
        next_op.rf_waddr       = rec.rd;
        next_op.rf_we          = (rec.kind == "L");
        next_op.memop_rd       = (rec.kind == "L");
        next_op.memop_wr       = (rec.kind == "S");
        next_op.memop_sign_ext = rec.sign;
        next_op.memop_type     = rec.mtype;
        op_valid <= 1'b1;
        op       <= next_op;
        // Taken on the first edge with no hazard
        @(posedge clk);
        while (hazard) begin
            @(posedge clk);
        end
        if (rec.kind == "L") begin
            ld.rd    = rec.rd;
            ld.value = rec.expected;
            load_q.push_back(ld);
            last_load_addr = rec.addr;
        end else begin
            st.addr       = rec.addr;
            st.data       = rec.data;
            st.memop_type = rec.mtype;
            store_q.push_back(st);
        end
    endtask

    task automatic finish_group(input int idx, input int err_start, input int chk_start);
        op_valid <= 1'b0;
        while (load_q.size() != 0 || store_q.size() != 0) begin
            @(posedge clk);
        end
        $display("Group %0s finished: %0d checks, %0d errors", group_names[idx],
                 checks - chk_start, errors - err_start);
    endtask

    // Load results in issue order
    always @(posedge clk) begin : load_scoreboard
        load_exp_t exp_ld;
        if (rst_n && rf_we) begin
            if (load_q.size() == 0) begin
                errors++;
                $display("Register write to x%0d arrived with no load outstanding", rf_waddr);
            end else begin
                exp_ld = load_q.pop_front();
                check_value("op_res_o", op_res, exp_ld.value);
                check_value("rf_waddr_o", 32'(rf_waddr), 32'(exp_ld.rd));
            end
        end
    end

    // Store drains in program order
    always @(posedge clk) begin : store_scoreboard
        segre_pkg::sb_entry_t exp_st;
        if (rst_n && mm_wr && mm_data_rdy) begin
            if (store_q.size() == 0) begin
                errors++;
                $display("Memory write to %h happened with no store outstanding", mm_wr_addr);
            end else begin
                exp_st = store_q.pop_front();
                check_value("mm_wr_addr_o", mm_wr_addr, exp_st.addr);
                check_value("mm_wr_data_type_o", 32'(mm_wr_data_type), 32'(exp_st.memop_type));
                check_value("mm_wr_data_o", mm_wr_data, exp_st.data);
            end
        end
    end

    // A fill always serves the load held in TL, four words per lane
    always @(posedge clk) begin : fill_check
        if (rst_n && mm_rd && mm_data_rdy) begin
            check_value("mm_addr_o", mm_addr, {last_load_addr[31:4], 4'h0});
        end
    end

    initial begin : watchdog
        wait (rst_n === 1'b1);
        #(40 * num_lines * CLK_PERIOD);
        $display("Timeout: tests still running after %0d cycles", 40 * num_lines);
        $display("Test failed");
        $finish;
    end

    initial begin : main_flow
        int group_idx;
        int err_start;
        int chk_start;
        errors         = 0;
        checks         = 0;
        num_lines      = 0;
        last_load_addr = '0;
        rst_n          = 1'b0;
        op_valid       = 1'b0;
        op             = '0;
        group_idx      = -1;
        err_start      = 0;
        chk_start      = 0;
        read_tests();
        repeat (4) @(posedge clk);
        // Outputs idle under reset
        check_value("hazard_o", 32'(hazard), 32'h0);
        check_value("rf_we_o", 32'(rf_we), 32'h0);
        check_value("mm_rd_o", 32'(mm_rd), 32'h0);
        check_value("mm_wr_o", 32'(mm_wr), 32'h0);
        rst_n <= 1'b1;
        foreach (tests[i]) begin
            if (tests[i].kind == "G") begin
                if (group_idx >= 0) begin
                    finish_group(group_idx, err_start, chk_start);
                end
                group_idx = tests[i].data;
                err_start = errors;
                chk_start = checks;
            end else begin
                issue_op(tests[i]);
            end
        end
        if (group_idx >= 0) begin
            finish_group(group_idx, err_start, chk_start);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_segre_mem_subsys

// ==== tests/segre_main_memory_model.sv ====
`timescale 1ns/1ps

module segre_main_memory_model #(
    parameter int          MEM_WORDS = 1024,
    parameter logic [31:0] SEED      = 32'd33
) (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   mm_rd_i,
    input  logic                                   mm_wr_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]        mm_addr_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]        mm_wr_addr_i,
    input  logic [segre_pkg::WORD_SIZE-1:0]        mm_wr_data_i,
    input  segre_pkg::memop_data_type_e            mm_wr_type_i,
    output logic                                   mm_data_rdy_o,
    output logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_rd_data_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] lcg_state;
    logic [2:0]  wait_cnt;
    logic        busy;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [IDX_W-1:0] word_index(input logic [31:0] addr);
        return addr[IDX_W+1:2];
    endfunction

    // Lane word 0 sits in the low bits
    function automatic logic [127:0] read_lane(input logic [31:0] addr);
        logic [IDX_W-1:0] base;
        base = word_index({addr[31:4], 4'b0000});
        return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
    endfunction

    task automatic store_bytes(input logic [31:0] addr, input logic [31:0] data,
                               input segre_pkg::memop_data_type_e mtype);
        logic [31:0] word;
        word = mem[word_index(addr)];
        case (mtype)
            segre_pkg::BYTE: word[addr[1:0]*8 +: 8] = data[7:0];
            segre_pkg::HALF: word[addr[1]*16 +: 16] = data[15:0];
            default:         word = data;
        endcase
        mem[word_index(addr)] = word;
    endtask

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'(i * 4) ^ 32'hA5A5A5A5;
        end
        lcg_state     = SEED;
        mm_data_rdy_o = 1'b0;
        mm_rd_data_o  = '0;
    end

    // Ready comes 1 to 8 cycles after a request is first seen
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            mm_data_rdy_o <= 1'b0;
            busy          <= 1'b0;
            wait_cnt      <= '0;
        end else if (mm_data_rdy_o) begin
            mm_data_rdy_o <= 1'b0;
            busy          <= 1'b0;
        end else if (mm_rd_i || mm_wr_i) begin
            if (!busy) begin
                busy      <= 1'b1;
                lcg_state = lcg_next(lcg_state);
                wait_cnt  <= lcg_state[18:16];
            end else if (wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                mm_data_rdy_o <= 1'b1;
                if (mm_rd_i) begin
                    mm_rd_data_o <= read_lane(mm_addr_i);
                end else begin
                    store_bytes(mm_wr_addr_i, mm_wr_data_i, mm_wr_type_i);
                end
            end
        end
    end

endmodule : segre_main_memory_model

// ==== hw/segre_mem_subsys.sv ====
`timescale 1ns/1ps

module segre_mem_subsys #(
    parameter int SB_DEPTH     = 4,
    parameter int DCACHE_LINES = 4
) (
    // Clock and reset
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    // Upstream operation
    input  logic                                   op_valid_i,
    input  segre_pkg::core_tl_t                    op_i,
    output logic                                   hazard_o,
    // Register file write port
    output logic [segre_pkg::WORD_SIZE-1:0]        op_res_o,
    output logic                                   rf_we_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0]    rf_waddr_o,
    // Main memory
    input  logic                                   mm_data_rdy_i,
    input  logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_rd_data_i,
    output logic [segre_pkg::WORD_SIZE-1:0]        mm_wr_data_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_addr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_wr_addr_o,
    output logic                                   mm_rd_o,
    output logic                                   mm_wr_o,
    output segre_pkg::memop_data_type_e            mm_wr_data_type_o
);

    segre_pkg::core_mem_t     core_mem;
    segre_pkg::core_hazards_t core_hazards;

    // Store buffer links
    logic                            sb_push;
    segre_pkg::sb_entry_t            sb_push_entry;
    logic [segre_pkg::ADDR_SIZE-1:0] sb_lookup_addr;
    logic                            sb_full;
    logic                            sb_hit;
    logic                            sb_valid;
    segre_pkg::sb_entry_t            sb_head;
    logic                            sb_pop;

    // Cache fill links
    logic                                   dc_miss;
    logic [segre_pkg::ADDR_SIZE-1:0]        dc_addr;
    logic                                   dc_mmu_data_rdy;
    logic [segre_pkg::DCACHE_LANE_SIZE-1:0] dc_data;

    // Either hazard freezes TL and upstream
    assign hazard_o = core_hazards.tl | core_hazards.sb;

    segre_tl_stage #(
        .SB_DEPTH     (SB_DEPTH),
        .DCACHE_LINES (DCACHE_LINES)
    ) tl_stage (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .op_valid_i        (op_valid_i),
        .op_i              (op_i),
        .stall_i           (hazard_o),
        .sb_hit_i          (sb_hit),
        .sb_full_i         (sb_full),
        .sb_push_o         (sb_push),
        .sb_entry_o        (sb_push_entry),
        .sb_lookup_addr_o  (sb_lookup_addr),
        .mmu_data_rdy_i    (dc_mmu_data_rdy),
        .mmu_data_i        (dc_data),
        .mmu_miss_o        (dc_miss),
        .mmu_addr_o        (dc_addr),
        .mem_op_o          (core_mem),
        .pipeline_hazard_o (core_hazards)
    );

    segre_store_buffer #(
        .SB_DEPTH (SB_DEPTH)
    ) store_buffer (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .push_i        (sb_push),
        .entry_i       (sb_push_entry),
        .lookup_addr_i (sb_lookup_addr),
        .full_o        (sb_full),
        .hit_o         (sb_hit),
        .pop_i         (sb_pop),
        .head_valid_o  (sb_valid),
        .head_o        (sb_head)
    );

    segre_mmu mmu (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .dc_miss_i         (dc_miss),
        .dc_addr_i         (dc_addr),
        .dc_mmu_data_rdy_o (dc_mmu_data_rdy),
        .dc_data_o         (dc_data),
        .sb_valid_i        (sb_valid),
        .sb_entry_i        (sb_head),
        .sb_pop_o          (sb_pop),
        .mm_data_rdy_i     (mm_data_rdy_i),
        .mm_rd_data_i      (mm_rd_data_i),
        .mm_rd_o           (mm_rd_o),
        .mm_wr_o           (mm_wr_o),
        .mm_addr_o         (mm_addr_o),
        .mm_wr_addr_o      (mm_wr_addr_o),
        .mm_wr_data_o      (mm_wr_data_o),
        .mm_wr_data_type_o (mm_wr_data_type_o)
    );

    segre_mem_stage mem_stage (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .mem_op_i   (core_mem),
        .op_res_o   (op_res_o),
        .rf_we_o    (rf_we_o),
        .rf_waddr_o (rf_waddr_o)
    );

endmodule : segre_mem_subsys

// ==== hw/segre_mem_stage.sv ====
`timescale 1ns/1ps

module segre_mem_stage (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    // From TL
    input  segre_pkg::core_mem_t                mem_op_i,
    // Register file write port
    output logic [segre_pkg::WORD_SIZE-1:0]     op_res_o,
    output logic                                rf_we_o,
    output logic [segre_pkg::REG_ADDR_SIZE-1:0] rf_waddr_o
);

    logic [segre_pkg::WORD_SIZE-1:0] shifted;
    logic [segre_pkg::WORD_SIZE-1:0] load_data;

    // Byte or half moved down to bit 0, then extended
    always_comb begin
        shifted = mem_op_i.word >> {mem_op_i.offset, 3'b000};
        case (mem_op_i.memop_type)
            segre_pkg::BYTE: begin
                load_data = {{24{mem_op_i.sign_ext & shifted[7]}}, shifted[7:0]};
            end
            segre_pkg::HALF: begin
                load_data = {{16{mem_op_i.sign_ext & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                load_data = mem_op_i.word;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rf_we_o <= 1'b0;
        end else begin
            rf_we_o <= mem_op_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        op_res_o   <= load_data;
        rf_waddr_o <= mem_op_i.rf_waddr;
    end

endmodule : segre_mem_stage

// ==== hw/segre_mmu.sv ====
`timescale 1ns/1ps

module segre_mmu (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    // Data cache
    input  logic                                   dc_miss_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0]        dc_addr_i,
    output logic                                   dc_mmu_data_rdy_o,
    output logic [segre_pkg::DCACHE_LANE_SIZE-1:0] dc_data_o,
    // Store buffer
    input  logic                                   sb_valid_i,
    input  segre_pkg::sb_entry_t                   sb_entry_i,
    output logic                                   sb_pop_o,
    // Main memory
    input  logic                                   mm_data_rdy_i,
    input  logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mm_rd_data_i,
    output logic                                   mm_rd_o,
    output logic                                   mm_wr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_addr_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mm_wr_addr_o,
    output logic [segre_pkg::WORD_SIZE-1:0]        mm_wr_data_o,
    output segre_pkg::memop_data_type_e            mm_wr_data_type_o
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } mmu_state_e;

    mmu_state_e                      state;
    logic [segre_pkg::ADDR_SIZE-1:0] rd_addr_q;
    segre_pkg::sb_entry_t            wr_entry_q;

    // Fill first, the drain can wait
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (dc_miss_i) begin
                        state <= READ;
                    end else if (sb_valid_i) begin
                        state <= WRITE;
                    end
                end
                READ, WRITE: begin
                    if (mm_data_rdy_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request payload captured when leaving IDLE
    always_ff @(posedge clk_i) begin
        if (state == IDLE) begin
            rd_addr_q  <= dc_addr_i;
            wr_entry_q <= sb_entry_i;
        end
    end

    assign mm_rd_o           = (state == READ);
    assign mm_wr_o           = (state == WRITE);
    assign mm_addr_o         = rd_addr_q;
    assign mm_wr_addr_o      = wr_entry_q.addr;
    assign mm_wr_data_o      = wr_entry_q.data;
    assign mm_wr_data_type_o = wr_entry_q.memop_type;

    assign dc_mmu_data_rdy_o = mm_rd_o && mm_data_rdy_i;
    assign dc_data_o         = mm_rd_data_i;
    assign sb_pop_o          = mm_wr_o && mm_data_rdy_i;

    a_rd_wr_exclusive : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mm_rd_o && mm_wr_o));

endmodule : segre_mmu

// ==== hw/segre_store_buffer.sv ====
`timescale 1ns/1ps

module segre_store_buffer #(
    parameter int SB_DEPTH = 4
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    // Producer side
    input  logic                            push_i,
    input  segre_pkg::sb_entry_t            entry_i,
    input  logic [segre_pkg::ADDR_SIZE-1:0] lookup_addr_i,
    output logic                            full_o,
    output logic                            hit_o,
    // Drain side
    input  logic                            pop_i,
    output logic                            head_valid_o,
    output segre_pkg::sb_entry_t            head_o
);

    localparam int PTR_W = $clog2(SB_DEPTH);
    localparam int OFF_W = segre_pkg::DCACHE_OFFSET_BITS;

    segre_pkg::sb_entry_t entries [SB_DEPTH];
    logic [SB_DEPTH-1:0]  occupied;
    logic [SB_DEPTH-1:0]  match;
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;

    assign full_o       = &occupied;
    assign head_valid_o = occupied[rd_ptr];
    assign head_o       = entries[rd_ptr];

    // Compared per lane, so a fill never overtakes a store into the same lane
    always_comb begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            match[i] = occupied[i] &&
                (entries[i].addr[segre_pkg::ADDR_SIZE-1:OFF_W] ==
                 lookup_addr_i[segre_pkg::ADDR_SIZE-1:OFF_W]);
        end
    end

    assign hit_o = |match;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            occupied <= '0;
        end else begin
            if (push_i) begin
                occupied[wr_ptr] <= 1'b1;
                wr_ptr           <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                occupied[rd_ptr] <= 1'b0;
                rd_ptr           <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            entries[wr_ptr] <= entry_i;
        end
    end

    a_push_not_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_o);

    // Pop comes from the MMU once memory has taken the head
    a_pop_not_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> head_valid_o);

endmodule : segre_store_buffer

// ==== hw/segre_tl_stage.sv ====
`timescale 1ns/1ps

module segre_tl_stage #(
    parameter int SB_DEPTH     = 4,
    parameter int DCACHE_LINES = 4
) (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    // Upstream operation
    input  logic                                   op_valid_i,
    input  segre_pkg::core_tl_t                    op_i,
    input  logic                                   stall_i,
    // Store buffer
    input  logic                                   sb_hit_i,
    input  logic                                   sb_full_i,
    output logic                                   sb_push_o,
    output segre_pkg::sb_entry_t                   sb_entry_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        sb_lookup_addr_o,
    // MMU
    input  logic                                   mmu_data_rdy_i,
    input  logic [segre_pkg::DCACHE_LANE_SIZE-1:0] mmu_data_i,
    output logic                                   mmu_miss_o,
    output logic [segre_pkg::ADDR_SIZE-1:0]        mmu_addr_o,
    // MEM stage and hazards
    output segre_pkg::core_mem_t                   mem_op_o,
    output segre_pkg::core_hazards_t               pipeline_hazard_o
);

    localparam int OFF_W = segre_pkg::DCACHE_OFFSET_BITS;
    localparam int IDX_W = $clog2(DCACHE_LINES);
    localparam int TAG_W = segre_pkg::ADDR_SIZE - OFF_W - IDX_W;
    localparam int WS    = segre_pkg::WORD_SIZE;

    // Pointer and index widths rely on powers of two
    if ((DCACHE_LINES < 2) || ((DCACHE_LINES & (DCACHE_LINES - 1)) != 0) ||
        (SB_DEPTH < 2) || ((SB_DEPTH & (SB_DEPTH - 1)) != 0)) begin : g_param_check
        $error("SB_DEPTH and DCACHE_LINES must be powers of two, at least 2");
    end

    logic                tl_valid;
    segre_pkg::core_tl_t tl_op;

    logic [segre_pkg::DCACHE_LANE_SIZE-1:0] lane_data [DCACHE_LINES];
    logic [TAG_W-1:0]                       lane_tag  [DCACHE_LINES];
    logic [DCACHE_LINES-1:0]                lane_valid;

    logic [IDX_W-1:0]   idx;
    logic [TAG_W-1:0]   tag;
    logic [OFF_W-3:0]   word_sel;
    logic [1:0]         byte_off;
    logic               cache_hit;
    logic [WS-1:0]      cached_word;
    logic [WS-1:0]      merged_word;
    logic               is_load;
    logic               is_store;
    logic               load_done;

    // Operation register, held while any stage hazard is up
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tl_valid <= 1'b0;
        end else if (!stall_i) begin
            tl_valid <= op_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            tl_op <= op_i;
        end
    end

    assign idx      = tl_op.alu_res[OFF_W +: IDX_W];
    assign tag      = tl_op.alu_res[segre_pkg::ADDR_SIZE-1 -: TAG_W];
    assign word_sel = tl_op.alu_res[OFF_W-1:2];
    assign byte_off = tl_op.alu_res[1:0];

    assign cache_hit   = lane_valid[idx] && (lane_tag[idx] == tag);
    assign cached_word = lane_data[idx][word_sel*WS +: WS];

    // Store bytes merged into the cached word
    always_comb begin
        merged_word = cached_word;
        case (tl_op.memop_type)
            segre_pkg::BYTE: merged_word[byte_off*8 +: 8]     = tl_op.rf_st_data[7:0];
            segre_pkg::HALF: merged_word[byte_off[1]*16 +: 16] = tl_op.rf_st_data[15:0];
            default:         merged_word = tl_op.rf_st_data;
        endcase
    end

    assign is_load   = tl_valid && tl_op.memop_rd;
    assign is_store  = tl_valid && tl_op.memop_wr;
    assign load_done = is_load && !sb_hit_i && cache_hit;

    // A load waits on pending stores first, then on its fill
    assign pipeline_hazard_o.tl = is_load && !sb_hit_i && !cache_hit;
    assign pipeline_hazard_o.sb = (is_store && sb_full_i) || (is_load && sb_hit_i);

    assign mmu_miss_o = pipeline_hazard_o.tl;
    assign mmu_addr_o = {tl_op.alu_res[segre_pkg::ADDR_SIZE-1:OFF_W], {OFF_W{1'b0}}};

    assign sb_push_o        = is_store && !sb_full_i;
    assign sb_entry_o       = '{addr: tl_op.alu_res, data: tl_op.rf_st_data,
                                memop_type: tl_op.memop_type};
    assign sb_lookup_addr_o = tl_op.alu_res;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lane_valid <= '0;
        end else if (mmu_data_rdy_i) begin
            lane_valid[idx] <= 1'b1;
        end
    end

    // Fill replaces the lane, a store only touches a present one
    always_ff @(posedge clk_i) begin
        if (mmu_data_rdy_i) begin
            lane_tag[idx]  <= tag;
            lane_data[idx] <= mmu_data_i;
        end else if (sb_push_o && cache_hit) begin
            lane_data[idx][word_sel*WS +: WS] <= merged_word;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_op_o.valid <= 1'b0;
        end else begin
            mem_op_o.valid      <= load_done && tl_op.rf_we;
            mem_op_o.word       <= cached_word;
            mem_op_o.offset     <= byte_off;
            mem_op_o.memop_type <= tl_op.memop_type;
            mem_op_o.sign_ext   <= tl_op.memop_sign_ext;
            mem_op_o.rf_waddr   <= tl_op.rf_waddr;
        end
    end

    // Full flag comes from the buffer itself
    a_no_push_when_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        sb_full_i |-> !sb_push_o);

endmodule : segre_tl_stage

// ==== hw/segre_pkg.sv ====
package segre_pkg;

    parameter int WORD_SIZE        = 32;
    parameter int ADDR_SIZE        = 32;
    parameter int DCACHE_LANE_SIZE = 128;
    parameter int REG_ADDR_SIZE    = 5;
    // Byte offset bits inside one cache lane
    parameter int DCACHE_OFFSET_BITS = $clog2(DCACHE_LANE_SIZE / 8);

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_data_type_e;

    // Operation handed over by the EX stage
    typedef struct packed {
        logic [ADDR_SIZE-1:0]     alu_res;
        logic [WORD_SIZE-1:0]     rf_st_data;
        logic [REG_ADDR_SIZE-1:0] rf_waddr;
        logic                     rf_we;
        logic                     memop_rd;
        logic                     memop_wr;
        logic                     memop_sign_ext;
        memop_data_type_e         memop_type;
    } core_tl_t;

    // Load leaving TL, word still raw
    typedef struct packed {
        logic                     valid;
        logic [WORD_SIZE-1:0]     word;
        logic [1:0]               offset;
        memop_data_type_e         memop_type;
        logic                     sign_ext;
        logic [REG_ADDR_SIZE-1:0] rf_waddr;
    } core_mem_t;

    // Store waiting for main memory, data unshifted as in the register
    typedef struct packed {
        logic [ADDR_SIZE-1:0] addr;
        logic [WORD_SIZE-1:0] data;
        memop_data_type_e     memop_type;
    } sb_entry_t;

    typedef struct packed {
        logic tl;
        logic sb;
    } core_hazards_t;

endpackage : segre_pkg
